// File: design/rs_pkg.sv
// Execution cluster package
// Widths, word types, ALU operation codes and exception codes shared
// by the reservation stations, the ALUs and the CDB arbiter
package rs_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int XLEN        = 32;   // Operand and result width
    localparam int ROB_IDX_LEN = 4;    // 16 ROB tags
    localparam int RS_DEPTH    = 4;    // Entries per RS
    localparam int RS_IDX_LEN  = 2;    // Entry index width
    localparam int EU_CTL_LEN  = 2;    // ALU operation width

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [XLEN-1:0]        xlen_t;
    typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;
    typedef logic [RS_IDX_LEN-1:0]  rs_idx_t;
    typedef logic [EU_CTL_LEN-1:0]  eu_ctl_t;
    typedef logic [1:0]             except_code_t;

    // ALU operations
    localparam eu_ctl_t OP_ADD = 2'd0;
    localparam eu_ctl_t OP_SUB = 2'd1;
    localparam eu_ctl_t OP_XOR = 2'd2;
    localparam eu_ctl_t OP_ILL = 2'd3;    // Reserved, traps

    // Exception codes
    localparam except_code_t EXC_NONE       = 2'd0;
    localparam except_code_t EXC_ILLEGAL_OP = 2'd1;

endpackage

// File: design/prio_enc.sv
// Priority encoder
// Returns the index of the lowest set line and flags whether any is set
`timescale 1ns/1ps

module prio_enc
    import rs_pkg::*;
(
    input  logic [RS_DEPTH-1:0] lines_i,
    output rs_idx_t             enc_o,
    output logic                valid_o
);

    // Scan from the top down so the lowest set line wins
    always_comb begin
        enc_o   = '0;
        valid_o = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o   = rs_idx_t'(i);
                valid_o = 1'b1;
            end
        end
    end

endmodule

// File: design/generic_rs.sv
// Generic reservation station
// Holds issued instructions until both operands are known, dispatches
// them to the ALU, stores the result and requests the CDB to broadcast it
`timescale 1ns/1ps

module generic_rs
    import rs_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    // Issue side
    input  logic         issue_valid_i,
    output logic         issue_ready_o,
    input  eu_ctl_t      eu_ctl_i,
    input  logic         rs1_ready_i,
    input  rob_idx_t     rs1_idx_i,
    input  xlen_t        rs1_value_i,
    input  logic         rs2_ready_i,
    input  rob_idx_t     rs2_idx_i,
    input  xlen_t        rs2_value_i,
    input  rob_idx_t     dest_idx_i,
    // To the ALU
    output logic         eu_valid_o,
    output eu_ctl_t      eu_ctl_o,
    output xlen_t        eu_rs1_o,
    output xlen_t        eu_rs2_o,
    output rs_idx_t      eu_entry_idx_o,
    // From the ALU
    input  logic         eu_valid_i,
    input  rs_idx_t      eu_entry_idx_i,
    input  xlen_t        eu_result_i,
    input  logic         eu_except_raised_i,
    input  except_code_t eu_except_code_i,
    // CDB request
    output logic         cdb_req_o,
    input  logic         cdb_gnt_i,
    output rob_idx_t     rs_rob_idx_o,
    output xlen_t        rs_value_o,
    output logic         rs_except_raised_o,
    output except_code_t rs_except_code_o,
    // CDB snoop
    input  logic         cdb_valid_i,
    input  rob_idx_t     cdb_idx_i,
    input  xlen_t        cdb_value_i,
    input  logic         cdb_except_raised_i
);

    // --------------------------------------------------
    // Entry storage
    // --------------------------------------------------
    logic [RS_DEPTH-1:0] valid_q, busy_q;          // Allocated / in the ALU
    logic [RS_DEPTH-1:0] rs1_rdy_q, rs2_rdy_q;     // Operand values present
    logic [RS_DEPTH-1:0] res_rdy_q, exc_q;         // Result written back, trap flag
    eu_ctl_t             ctl_q      [RS_DEPTH];
    rob_idx_t            rs1_tag_q  [RS_DEPTH];    // Producer tags of the operands
    rob_idx_t            rs2_tag_q  [RS_DEPTH];
    rob_idx_t            dest_q     [RS_DEPTH];    // Own ROB tag
    xlen_t               rs1_val_q  [RS_DEPTH];
    xlen_t               rs2_val_q  [RS_DEPTH];
    xlen_t               res_val_q  [RS_DEPTH];
    except_code_t        exc_code_q [RS_DEPTH];

    // Selector results
    logic [RS_DEPTH-1:0] ex_lines, res_lines;
    logic [RS_DEPTH-1:0] cap1, cap2;               // Operand captured from the CDB
    rs_idx_t             new_idx, ex_idx, cdb_sel;
    logic                new_found, ex_found, res_found;
    logic                do_insert;

    always_comb begin
        ex_lines  = valid_q & rs1_rdy_q & rs2_rdy_q & ~busy_q & ~res_rdy_q;
        res_lines = valid_q & res_rdy_q;
        // Only entries present before the edge see the broadcast
        for (int i = 0; i < RS_DEPTH; i++) begin
            cap1[i] = cdb_valid_i && !cdb_except_raised_i && valid_q[i] &&
                      !rs1_rdy_q[i] && (rs1_tag_q[i] == cdb_idx_i);
            cap2[i] = cdb_valid_i && !cdb_except_raised_i && valid_q[i] &&
                      !rs2_rdy_q[i] && (rs2_tag_q[i] == cdb_idx_i);
        end
    end

    prio_enc u_new_sel (.lines_i(~valid_q),  .enc_o(new_idx), .valid_o(new_found));
    prio_enc u_ex_sel  (.lines_i(ex_lines),  .enc_o(ex_idx),  .valid_o(ex_found));
    prio_enc u_cdb_sel (.lines_i(res_lines), .enc_o(cdb_sel), .valid_o(res_found));

    assign issue_ready_o = new_found && !flush_i;
    assign do_insert     = issue_valid_i && issue_ready_o;

    // --------------------------------------------------
    // Entry status
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= '0;
            busy_q    <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            res_rdy_q <= '0;
            exc_q     <= '0;
        end else if (flush_i) begin
            valid_q   <= '0;    // In-flight work is dropped
            busy_q    <= '0;
            res_rdy_q <= '0;
            exc_q     <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (cap1[i]) rs1_rdy_q[i] <= 1'b1;
                if (cap2[i]) rs2_rdy_q[i] <= 1'b1;
            end
            if (ex_found) busy_q[ex_idx] <= 1'b1;  // ALU never stalls
            if (eu_valid_i) begin
                res_rdy_q[eu_entry_idx_i] <= 1'b1;
                exc_q[eu_entry_idx_i]     <= eu_except_raised_i;
            end
            if (cdb_gnt_i) valid_q[cdb_sel] <= 1'b0;  // Broadcast done
            if (do_insert) begin
                valid_q[new_idx]   <= 1'b1;
                busy_q[new_idx]    <= 1'b0;
                rs1_rdy_q[new_idx] <= rs1_ready_i;
                rs2_rdy_q[new_idx] <= rs2_ready_i;
                res_rdy_q[new_idx] <= 1'b0;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cap1[i]) rs1_val_q[i] <= cdb_value_i;
            if (cap2[i]) rs2_val_q[i] <= cdb_value_i;
        end
        if (eu_valid_i) begin
            res_val_q[eu_entry_idx_i]  <= eu_result_i;
            exc_code_q[eu_entry_idx_i] <= eu_except_code_i;
        end
        if (do_insert) begin
            ctl_q[new_idx]     <= eu_ctl_i;
            rs1_tag_q[new_idx] <= rs1_idx_i;
            rs1_val_q[new_idx] <= rs1_value_i;
            rs2_tag_q[new_idx] <= rs2_idx_i;
            rs2_val_q[new_idx] <= rs2_value_i;
            dest_q[new_idx]    <= dest_idx_i;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign eu_valid_o     = ex_found;
    assign eu_ctl_o       = ctl_q[ex_idx];
    assign eu_rs1_o       = rs1_val_q[ex_idx];
    assign eu_rs2_o       = rs2_val_q[ex_idx];
    assign eu_entry_idx_o = ex_idx;

    assign cdb_req_o          = res_found;
    assign rs_rob_idx_o       = dest_q[cdb_sel];
    assign rs_value_o         = res_val_q[cdb_sel];
    assign rs_except_raised_o = exc_q[cdb_sel];
    assign rs_except_code_o   = exc_code_q[cdb_sel];

    // A result can only come back for an entry whose operands were complete
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_order_chk
        a_res_after_ops: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (valid_q[i] && res_rdy_q[i]) |-> (rs1_rdy_q[i] && rs2_rdy_q[i]));
    end

    // Issue lands only in a free entry, so never when the RS is full
    a_no_issue_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        do_insert |-> !valid_q[new_idx]);

endmodule

// File: design/alu_unit.sv
// Two-stage integer ALU
// Stage 1 latches the operands, stage 2 computes and latches the result;
// the reserved operation code traps with a zero result
`timescale 1ns/1ps

module alu_unit
    import rs_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         valid_i,
    input  eu_ctl_t      ctl_i,
    input  xlen_t        rs1_i,
    input  xlen_t        rs2_i,
    input  rs_idx_t      entry_idx_i,
    output logic         valid_o,
    output xlen_t        result_o,
    output rs_idx_t      entry_idx_o,
    output logic         except_raised_o,
    output except_code_t except_code_o
);

    logic    s1_valid_q, s2_valid_q;
    eu_ctl_t s1_ctl_q;
    xlen_t   s1_rs1_q, s1_rs2_q;
    rs_idx_t s1_idx_q;

    // Stage valids, cleared by flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= valid_i && !flush_i;
            s2_valid_q <= s1_valid_q && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_ctl_q        <= ctl_i;      // Stage 1
        s1_rs1_q        <= rs1_i;
        s1_rs2_q        <= rs2_i;
        s1_idx_q        <= entry_idx_i;
        entry_idx_o     <= s1_idx_q;   // Stage 2
        except_raised_o <= (s1_ctl_q == OP_ILL);
        except_code_o   <= (s1_ctl_q == OP_ILL) ? EXC_ILLEGAL_OP : EXC_NONE;
        case (s1_ctl_q)
            OP_ADD:  result_o <= s1_rs1_q + s1_rs2_q;
            OP_SUB:  result_o <= s1_rs1_q - s1_rs2_q;
            OP_XOR:  result_o <= s1_rs1_q ^ s1_rs2_q;
            default: result_o <= '0;   // OP_ILL
        endcase
    end

    assign valid_o = s2_valid_q;

endmodule

// File: design/cdb_arbiter.sv
// CDB arbiter
// Grants the common data bus to one of two reservation stations in
// round-robin order and drives the winner's broadcast onto the bus
`timescale 1ns/1ps

module cdb_arbiter
    import rs_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         req0_i,
    input  rob_idx_t     rob_idx0_i,
    input  xlen_t        value0_i,
    input  logic         except_raised0_i,
    input  except_code_t except_code0_i,
    input  logic         req1_i,
    input  rob_idx_t     rob_idx1_i,
    input  xlen_t        value1_i,
    input  logic         except_raised1_i,
    input  except_code_t except_code1_i,
    output logic         gnt0_o,
    output logic         gnt1_o,
    output logic         cdb_valid_o,
    output rob_idx_t     cdb_idx_o,
    output xlen_t        cdb_value_o,
    output logic         cdb_except_raised_o,
    output except_code_t cdb_except_code_o
);

    logic last_q;   // RS1 won the last broadcast

    // On contention the side that lost last time goes first
    assign gnt0_o = req0_i && (!req1_i || last_q);
    assign gnt1_o = req1_i && (!req0_i || !last_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) last_q <= 1'b0;
        else if (gnt0_o || gnt1_o) last_q <= gnt1_o;
    end

    // Winner's fields onto the bus
    assign cdb_valid_o         = gnt0_o || gnt1_o;
    assign cdb_idx_o           = gnt1_o ? rob_idx1_i       : rob_idx0_i;
    assign cdb_value_o         = gnt1_o ? value1_i         : value0_i;
    assign cdb_except_raised_o = gnt1_o ? except_raised1_i : except_raised0_i;
    assign cdb_except_code_o   = gnt1_o ? except_code1_i   : except_code0_i;

    // A loser still requesting wins the next cycle
    a_gnt_fair: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req0_i && req1_i && gnt1_o ##1 req0_i) |-> gnt0_o);

    a_gnt_fair1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req0_i && req1_i && gnt0_o ##1 req1_i) |-> gnt1_o);

endmodule

// File: design/exec_cluster_top.sv
// Execution cluster top
// Two reservation station and ALU pairs sharing one CDB; the CDB goes
// out to the ROB and back to both stations for operand wake-up
`timescale 1ns/1ps

module exec_cluster_top
    import rs_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         issue_valid_i,
    input  logic         issue_unit_i,    // 0 selects RS0, 1 selects RS1
    input  eu_ctl_t      eu_ctl_i,
    input  logic         rs1_ready_i,
    input  rob_idx_t     rs1_idx_i,
    input  xlen_t        rs1_value_i,
    input  logic         rs2_ready_i,
    input  rob_idx_t     rs2_idx_i,
    input  xlen_t        rs2_value_i,
    input  rob_idx_t     dest_idx_i,
    output logic         issue_ready_o,
    output logic         cdb_valid_o,
    output rob_idx_t     cdb_idx_o,
    output xlen_t        cdb_value_o,
    output logic         cdb_except_raised_o,
    output except_code_t cdb_except_code_o
);

    // Per-unit wiring, index 0 is RS0/ALU0
    logic [1:0]   iss_valid, iss_ready;
    logic [1:0]   eu_valid, alu_valid, alu_exc;
    logic [1:0]   req, gnt, rs_exc;
    eu_ctl_t      eu_ctl   [2];
    xlen_t        eu_rs1   [2];
    xlen_t        eu_rs2   [2];
    rs_idx_t      eu_idx   [2];
    xlen_t        alu_res  [2];
    rs_idx_t      alu_idx  [2];
    except_code_t alu_code [2];
    rob_idx_t     rs_tag   [2];
    xlen_t        rs_val   [2];
    except_code_t rs_code  [2];

    // Issue steering
    assign iss_valid[0]  = issue_valid_i && !issue_unit_i;
    assign iss_valid[1]  = issue_valid_i && issue_unit_i;
    assign issue_ready_o = iss_ready[issue_unit_i];

    // --------------------------------------------------
    // RS and ALU pairs
    // --------------------------------------------------
    generic_rs u_rs0 (
        .clk_i, .rst_n_i, .flush_i,
        .issue_valid_i(iss_valid[0]), .issue_ready_o(iss_ready[0]),
        .eu_ctl_i, .rs1_ready_i, .rs1_idx_i, .rs1_value_i,
        .rs2_ready_i, .rs2_idx_i, .rs2_value_i, .dest_idx_i,
        .eu_valid_o(eu_valid[0]), .eu_ctl_o(eu_ctl[0]), .eu_rs1_o(eu_rs1[0]),
        .eu_rs2_o(eu_rs2[0]), .eu_entry_idx_o(eu_idx[0]),
        .eu_valid_i(alu_valid[0]), .eu_entry_idx_i(alu_idx[0]), .eu_result_i(alu_res[0]),
        .eu_except_raised_i(alu_exc[0]), .eu_except_code_i(alu_code[0]),
        .cdb_req_o(req[0]), .cdb_gnt_i(gnt[0]), .rs_rob_idx_o(rs_tag[0]),
        .rs_value_o(rs_val[0]), .rs_except_raised_o(rs_exc[0]), .rs_except_code_o(rs_code[0]),
        .cdb_valid_i(cdb_valid_o), .cdb_idx_i(cdb_idx_o), .cdb_value_i(cdb_value_o),
        .cdb_except_raised_i(cdb_except_raised_o)
    );

    generic_rs u_rs1 (
        .clk_i, .rst_n_i, .flush_i,
        .issue_valid_i(iss_valid[1]), .issue_ready_o(iss_ready[1]),
        .eu_ctl_i, .rs1_ready_i, .rs1_idx_i, .rs1_value_i,
        .rs2_ready_i, .rs2_idx_i, .rs2_value_i, .dest_idx_i,
        .eu_valid_o(eu_valid[1]), .eu_ctl_o(eu_ctl[1]), .eu_rs1_o(eu_rs1[1]),
        .eu_rs2_o(eu_rs2[1]), .eu_entry_idx_o(eu_idx[1]),
        .eu_valid_i(alu_valid[1]), .eu_entry_idx_i(alu_idx[1]), .eu_result_i(alu_res[1]),
        .eu_except_raised_i(alu_exc[1]), .eu_except_code_i(alu_code[1]),
        .cdb_req_o(req[1]), .cdb_gnt_i(gnt[1]), .rs_rob_idx_o(rs_tag[1]),
        .rs_value_o(rs_val[1]), .rs_except_raised_o(rs_exc[1]), .rs_except_code_o(rs_code[1]),
        .cdb_valid_i(cdb_valid_o), .cdb_idx_i(cdb_idx_o), .cdb_value_i(cdb_value_o),
        .cdb_except_raised_i(cdb_except_raised_o)
    );

    alu_unit u_alu0 (
        .clk_i, .rst_n_i, .flush_i,
        .valid_i(eu_valid[0]), .ctl_i(eu_ctl[0]), .rs1_i(eu_rs1[0]), .rs2_i(eu_rs2[0]),
        .entry_idx_i(eu_idx[0]), .valid_o(alu_valid[0]), .result_o(alu_res[0]),
        .entry_idx_o(alu_idx[0]), .except_raised_o(alu_exc[0]), .except_code_o(alu_code[0])
    );

    alu_unit u_alu1 (
        .clk_i, .rst_n_i, .flush_i,
        .valid_i(eu_valid[1]), .ctl_i(eu_ctl[1]), .rs1_i(eu_rs1[1]), .rs2_i(eu_rs2[1]),
        .entry_idx_i(eu_idx[1]), .valid_o(alu_valid[1]), .result_o(alu_res[1]),
        .entry_idx_o(alu_idx[1]), .except_raised_o(alu_exc[1]), .except_code_o(alu_code[1])
    );

    // Shared bus, also fed back to both stations
    cdb_arbiter u_cdb_arb (
        .clk_i, .rst_n_i,
        .req0_i(req[0]), .rob_idx0_i(rs_tag[0]), .value0_i(rs_val[0]),
        .except_raised0_i(rs_exc[0]), .except_code0_i(rs_code[0]),
        .req1_i(req[1]), .rob_idx1_i(rs_tag[1]), .value1_i(rs_val[1]),
        .except_raised1_i(rs_exc[1]), .except_code1_i(rs_code[1]),
        .gnt0_o(gnt[0]), .gnt1_o(gnt[1]),
        .cdb_valid_o, .cdb_idx_o, .cdb_value_o, .cdb_except_raised_o, .cdb_except_code_o
    );

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset
// 8 ns clock, active-low reset held for the first 3 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;    // 8 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o) rst_n_o = 1'b1;    // Release away from the active edge
    end

endmodule

// File: verif/tb_checker.sv
// CDB checker
// Reference model of the cluster: records every accepted issue, predicts
// its broadcast from the ALU rules and compares each CDB transfer
`timescale 1ns/1ps

module tb_checker
    import rs_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic [2:0]   phase_i,
    input  logic         issue_valid_i,
    input  logic         issue_ready_i,
    input  eu_ctl_t      eu_ctl_i,
    input  logic         rs1_ready_i,
    input  rob_idx_t     rs1_idx_i,
    input  xlen_t        rs1_value_i,
    input  logic         rs2_ready_i,
    input  rob_idx_t     rs2_idx_i,
    input  xlen_t        rs2_value_i,
    input  rob_idx_t     dest_idx_i,
    input  logic         cdb_valid_i,
    input  rob_idx_t     cdb_idx_i,
    input  xlen_t        cdb_value_i,
    input  logic         cdb_except_raised_i,
    input  except_code_t cdb_except_code_i,
    output logic [15:0]  pend_o,        // Issued, broadcast still due
    output logic [15:0]  exc_o,         // Predicted to trap
    output xlen_t        val_o [16],    // Predicted result per tag
    output int           chk_cnt_o,
    output int           err_cnt_o
);

    function automatic string test_name(input logic [2:0] ph);
        case (ph)
            3'd0:    return "independent";
            3'd1:    return "dependent";
            3'd2:    return "illegal_op";
            3'd3:    return "cdb_contention";
            3'd4:    return "rs_full";
            3'd5:    return "flush";
            default: return "after_flush";
        endcase
    endfunction

    // Result as the ALU rules define it
    function automatic xlen_t alu_model(input eu_ctl_t op, input xlen_t a, input xlen_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return '0;    // Trapping op
        endcase
    endfunction

    task automatic mismatch(input string what, input rob_idx_t tag, input xlen_t exp_v,
                            input xlen_t act_v);
        $display("CHECK FAILED %s: tag %0d %s expected %h actual %h",
                 test_name(phase_i), tag, what, exp_v, act_v);
        err_cnt_o++;
    endtask

    // --------------------------------------------------
    // Model update, one pass per rising edge
    // --------------------------------------------------
    always @(posedge clk_i) begin
        xlen_t        a, b;
        except_code_t exp_code;
        if (!rst_n_i) begin
            pend_o    = '0;
            exc_o     = '0;
            chk_cnt_o = 0;
            err_cnt_o = 0;
        end else begin
            // Broadcast first, an issue on the same edge must not see it
            if (cdb_valid_i) begin
                chk_cnt_o++;
                if (!pend_o[cdb_idx_i]) begin
                    $display("ERROR: %s: CDB carried tag %0d, which is not in flight",
                             test_name(phase_i), cdb_idx_i);
                    err_cnt_o++;
                end else begin
                    exp_code = exc_o[cdb_idx_i] ? EXC_ILLEGAL_OP : EXC_NONE;
                    if (cdb_value_i !== val_o[cdb_idx_i])
                        mismatch("value", cdb_idx_i, val_o[cdb_idx_i], cdb_value_i);
                    if (cdb_except_raised_i !== exc_o[cdb_idx_i])
                        mismatch("exception flag", cdb_idx_i, xlen_t'(exc_o[cdb_idx_i]),
                                 xlen_t'(cdb_except_raised_i));
                    if (cdb_except_code_i !== exp_code)
                        mismatch("exception code", cdb_idx_i, xlen_t'(exp_code),
                                 xlen_t'(cdb_except_code_i));
                    pend_o[cdb_idx_i] = 1'b0;    // Seen exactly once
                end
            end
            if (issue_valid_i && issue_ready_i) begin
                // Waiting operands take the producer's predicted result
                a = rs1_ready_i ? rs1_value_i : val_o[rs1_idx_i];
                b = rs2_ready_i ? rs2_value_i : val_o[rs2_idx_i];
                if ((!rs1_ready_i && !pend_o[rs1_idx_i]) || (!rs2_ready_i && !pend_o[rs2_idx_i])) begin
                    $display("ERROR: %s: tag %0d waits on a producer that is no longer in flight",
                             test_name(phase_i), dest_idx_i);
                    err_cnt_o++;
                end
                if (pend_o[dest_idx_i]) begin
                    $display("ERROR: %s: tag %0d issued again while still in flight",
                             test_name(phase_i), dest_idx_i);
                    err_cnt_o++;
                end
                val_o[dest_idx_i]  = alu_model(eu_ctl_i, a, b);
                exc_o[dest_idx_i]  = (eu_ctl_i == OP_ILL);
                pend_o[dest_idx_i] = 1'b1;
            end
            if (flush_i) pend_o = '0;    // Flushed work never reaches the CDB
        end
    end

endmodule

// File: verif/tb_top.sv
// Execution cluster testbench
// Random issue stream over both units with ROB tag bookkeeping, plus
// directed phases for CDB contention, RS full back-pressure and flush
`timescale 1ns/1ps

module tb_top
    import rs_pkg::*;
();

    localparam int ISSUE_TIMEOUT = 200;    // Cycles
    localparam int DRAIN_TIMEOUT = 400;

    logic         clk_i, rst_n_i, flush_i;
    logic         issue_valid_i, issue_unit_i, issue_ready_o;
    eu_ctl_t      eu_ctl_i;
    logic         rs1_ready_i, rs2_ready_i;
    rob_idx_t     rs1_idx_i, rs2_idx_i, dest_idx_i;
    xlen_t        rs1_value_i, rs2_value_i;
    logic         cdb_valid_o, cdb_except_raised_o;
    rob_idx_t     cdb_idx_o;
    xlen_t        cdb_value_o;
    except_code_t cdb_except_code_o;

    logic [15:0]  pend, exc;        // Model view per tag
    xlen_t        val [16];
    int           chk_cnt, chk_err, tb_err;
    logic [2:0]   phase;
    integer       seed = 32'h801d;
    rob_idx_t     next_tag, last_tag;

    tb_clock_gen u_clk (.clk_o(clk_i), .rst_n_o(rst_n_i));

    exec_cluster_top u_dut (.*);

    tb_checker u_chk (
        .clk_i, .rst_n_i, .flush_i, .phase_i(phase),
        .issue_valid_i, .issue_ready_i(issue_ready_o), .eu_ctl_i,
        .rs1_ready_i, .rs1_idx_i, .rs1_value_i, .rs2_ready_i, .rs2_idx_i, .rs2_value_i,
        .dest_idx_i, .cdb_valid_i(cdb_valid_o), .cdb_idx_i(cdb_idx_o),
        .cdb_value_i(cdb_value_o), .cdb_except_raised_i(cdb_except_raised_o),
        .cdb_except_code_i(cdb_except_code_o), .pend_o(pend), .exc_o(exc), .val_o(val),
        .chk_cnt_o(chk_cnt), .err_cnt_o(chk_err)
    );

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------
    task automatic finish_run();
        $display("Closing report: %0d broadcasts checked, %0d check errors, %0d other errors",
                 chk_cnt, chk_err, tb_err);
        if (chk_err + tb_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR: %s", msg);
        tb_err++;
        finish_run();
    endtask

    // Next tag free and fewer than 8 in flight, returns at a falling edge
    task automatic wait_slot();
        int cyc;
        cyc = 0;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        while ((pend[next_tag] || $countones(pend) >= 8) && cyc < ISSUE_TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
        end
        if (pend[next_tag] || $countones(pend) >= 8)
            abort_run("no free ROB tag, in-flight instructions never completed");
    endtask

    // dep < 0 gives a random ready operand, else the producer's tag
    task automatic issue_instr(input logic unit, input eu_ctl_t op, input int dep1,
                               input int dep2);
        int   cyc;
        logic done;
        cyc           = 0;
        done          = 1'b0;
        issue_valid_i = 1'b1;
        issue_unit_i  = unit;
        eu_ctl_i      = op;
        dest_idx_i    = next_tag;
        rs1_ready_i   = (dep1 < 0);
        rs1_idx_i     = rob_idx_t'(dep1);
        rs1_value_i   = $random(seed);
        rs2_ready_i   = (dep2 < 0);
        rs2_idx_i     = rob_idx_t'(dep2);
        rs2_value_i   = $random(seed);
        while (!done && cyc < ISSUE_TIMEOUT) begin
            // Producer done or on the bus now, the RS would miss it
            if (!rs1_ready_i && (!pend[rs1_idx_i] || (cdb_valid_o && cdb_idx_o == rs1_idx_i))) begin
                rs1_ready_i = 1'b1;
                rs1_value_i = val[rs1_idx_i];
            end
            if (!rs2_ready_i && (!pend[rs2_idx_i] || (cdb_valid_o && cdb_idx_o == rs2_idx_i))) begin
                rs2_ready_i = 1'b1;
                rs2_value_i = val[rs2_idx_i];
            end
            @(posedge clk_i);
            done = issue_ready_o;    // Pre-edge value decides acceptance
            if (!done) @(negedge clk_i);
            cyc++;
        end
        if (!done) abort_run("issue_ready_o stayed low, instruction was never accepted");
        last_tag = next_tag;
        next_tag = next_tag + 1'b1;    // Round robin over 16
    endtask

    // In-flight producer that does not trap, or -1
    function automatic int pick_dep(input logic use_deps);
        int cands[$];
        if (!use_deps || ($random(seed) & 1) == 0) return -1;
        for (int t = 0; t < 16; t++) begin
            if (pend[t] && !exc[t]) cands.push_back(t);
        end
        if (cands.size() == 0) return -1;
        return cands[$unsigned($random(seed)) % cands.size()];
    endfunction

    task automatic run_random(input int n, input logic use_deps, input int ill_one_in);
        eu_ctl_t op;
        logic    unit;
        int      d1, d2;
        for (int i = 0; i < n; i++) begin
            wait_slot();
            op = eu_ctl_t'($unsigned($random(seed)) % 3);
            if (ill_one_in > 0 && $unsigned($random(seed)) % ill_one_in == 0) op = OP_ILL;
            unit = logic'($random(seed) & 1);
            d1   = pick_dep(use_deps);
            d2   = pick_dep(use_deps);
            issue_instr(unit, op, d1, d2);
        end
    endtask

    // Waits for every tag to broadcast and counts refused issue edges
    task automatic drain(output int stalls);
        int cyc;
        cyc    = 0;
        stalls = 0;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        while (pend != '0 && cyc < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            if (!issue_ready_o) stalls++;
            @(negedge clk_i);
            cyc++;
        end
        if (pend != '0) abort_run("instructions in flight never reached the CDB");
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int stalls;
        int cyc;
        int prod;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_unit_i  = 1'b0;
        eu_ctl_i      = OP_ADD;
        rs1_ready_i   = 1'b1;
        rs1_idx_i     = '0;
        rs1_value_i   = '0;
        rs2_ready_i   = 1'b1;
        rs2_idx_i     = '0;
        rs2_value_i   = '0;
        dest_idx_i    = '0;
        next_tag      = '0;
        last_tag      = '0;
        tb_err        = 0;
        phase         = 3'd0;
        cyc           = 0;
        while (!rst_n_i && cyc < 20) begin
            @(negedge clk_i);
            cyc++;
        end
        if (!rst_n_i) abort_run("reset was never released");

        run_random(16, 1'b0, 0);    // Independent, no traps
        drain(stalls);
        phase = 3'd1;
        run_random(24, 1'b1, 0);
        drain(stalls);
        phase = 3'd2;
        run_random(12, 1'b1, 3);    // Traps frequent
        drain(stalls);

        // Consumers on both units wake on one broadcast and finish together
        phase = 3'd3;
        for (int r = 0; r < 3; r++) begin
            wait_slot();
            issue_instr(1'b0, OP_ADD, -1, -1);
            prod = int'(last_tag);
            for (int k = 0; k < 4; k++) begin
                wait_slot();
                issue_instr(logic'(k % 2), eu_ctl_t'(k % 3), prod, -1);
            end
        end
        drain(stalls);

        // Chain of 4 in RS0 keeps every entry busy
        phase = 3'd4;
        wait_slot();
        issue_instr(1'b0, OP_ADD, -1, -1);
        for (int k = 0; k < 3; k++) begin
            wait_slot();
            issue_instr(1'b0, OP_SUB, int'(last_tag), -1);
        end
        drain(stalls);
        if (stalls == 0) begin
            $display("ERROR: issue_ready_o never dropped while RS0 held 4 entries");
            tb_err++;
        end

        phase = 3'd5;
        run_random(6, 1'b1, 0);
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        flush_i       = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        repeat (12) @(negedge clk_i);    // Late broadcasts show up as unknown tags

        phase = 3'd6;
        run_random(24, 1'b1, 12);
        drain(stalls);
        finish_run();
    end

endmodule

// File: verilog.f
design/rs_pkg.sv
design/prio_enc.sv
design/generic_rs.sv
design/alu_unit.sv
design/cdb_arbiter.sv
design/exec_cluster_top.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run.sh
#!/bin/bash
# Build and run the execution cluster testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f verilog.f -o Vtb_top
./obj_dir/Vtb_top | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Result: test failed"
    exit 1
fi
echo "Result: test passed"
